//--- list.f
+incdir+sim
source/sha256_pkg.sv
source/sha256_sched_stage.sv
source/sha256_round_stage.sv
source/sha256_final_add.sv
source/sha256_pipeline.sv
sim/tb_sha256_pipeline.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_sha256_pipeline \
	-f list.f -o tb_sha256_pipeline || exit 1
output=$(./obj_dir/tb_sha256_pipeline 2>&1)
echo "$output"
echo "$output" | grep -qx "STATUS: PASS" && exit 0 || exit 1

//--- sim/sha256_model.svh
`ifndef SHA256_MODEL_SVH
`define SHA256_MODEL_SVH

// "abc", padded to one block
localparam sha256_pkg::block_t ABC_BLOCK = {
	32'h61626380, 32'h00000000, 32'h00000000, 32'h00000000,
	32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
	32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
	32'h00000000, 32'h00000000, 32'h00000000, 32'h00000018
};

localparam sha256_pkg::hash_state_u ABC_DIGEST = {
	32'hba7816bf, 32'h8f01cfea, 32'h414140de, 32'h5dae2223,
	32'hb00361a3, 32'h96177a9c, 32'hb410ff61, 32'hf20015ad
};

// 448-bit test string, message plus the 0x80 pad byte
localparam sha256_pkg::block_t TWO_BLOCK_0 = {
	32'h61626364, 32'h62636465, 32'h63646566, 32'h64656667,
	32'h65666768, 32'h66676869, 32'h6768696a, 32'h68696a6b,
	32'h696a6b6c, 32'h6a6b6c6d, 32'h6b6c6d6e, 32'h6c6d6e6f,
	32'h6d6e6f70, 32'h6e6f7071, 32'h80000000, 32'h00000000
};

// Second block carries only the bit length
localparam sha256_pkg::block_t TWO_BLOCK_1 = {
	32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
	32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
	32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000,
	32'h00000000, 32'h00000000, 32'h00000000, 32'h000001c0
};

localparam sha256_pkg::hash_state_u TWO_DIGEST = {
	32'h248d6a61, 32'hd20638b8, 32'he5c02693, 32'h0c3e6039,
	32'ha33ce459, 32'h64ff2167, 32'hf6ecedd4, 32'h19db06c1
};

function automatic logic [31:0] rot_right(input logic [31:0] x, input int n);
	logic [63:0] doubled;
	doubled = {x, x} >> n;
	return doubled[31:0];
endfunction

// Straight textbook compression of one block
function automatic sha256_pkg::hash_state_u compress_block(
	input sha256_pkg::hash_state_u chain,
	input sha256_pkg::block_t      blk
);
	logic [31:0]             w [0:63];
	logic [31:0]             v [0:7];
	logic [31:0]             s0;
	logic [31:0]             s1;
	logic [31:0]             t1;
	logic [31:0]             t2;
	sha256_pkg::hash_state_u result;
	for (int t = 0; t < 16; t++) begin
		w[t] = blk[t];
	end
	for (int t = 16; t < 64; t++) begin
		s0 = rot_right(w[t-15], 7) ^ rot_right(w[t-15], 18) ^ (w[t-15] >> 3);
		s1 = rot_right(w[t-2], 17) ^ rot_right(w[t-2], 19) ^ (w[t-2] >> 10);
		w[t] = w[t-16] + s0 + w[t-7] + s1;
	end
	for (int i = 0; i < 8; i++) begin
		v[i] = chain.words[i];
	end
	for (int t = 0; t < 64; t++) begin
		s1 = rot_right(v[4], 6) ^ rot_right(v[4], 11) ^ rot_right(v[4], 25);
		t1 = v[7] + s1 + ((v[4] & v[5]) ^ (~v[4] & v[6])) + sha256_pkg::round_k[t] + w[t];
		s0 = rot_right(v[0], 2) ^ rot_right(v[0], 13) ^ rot_right(v[0], 22);
		t2 = s0 + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
		v[7] = v[6];
		v[6] = v[5];
		v[5] = v[4];
		v[4] = v[3] + t1;
		v[3] = v[2];
		v[2] = v[1];
		v[1] = v[0];
		v[0] = t1 + t2;
	end
	for (int i = 0; i < 8; i++) begin
		result.words[i] = chain.words[i] + v[i];
	end
	return result;
endfunction

`endif

//--- sim/tb_sha256_pipeline.sv
`timescale 1ns/1ps

module tb_sha256_pipeline;

	`include "sha256_model.svh"

	localparam int LATENCY = 65;
	localparam int N_BURST = 80;
	localparam int N_MIXED = 200;
	localparam int PLANNED_ADVANCES = 5 + 3 * (LATENCY + 2) + N_BURST + LATENCY + 1
		+ N_MIXED + LATENCY + 1;
	localparam longint TIMEOUT_NS = longint'(PLANNED_ADVANCES + LATENCY) * 40 * 2;

	typedef struct packed {
		sha256_pkg::hash_state_u digest;
		logic [31:0]             adv_index;
	} expect_t;

	logic                    CLK;
	logic                    RST;
	logic                    adv_i;
	logic                    valid_i;
	sha256_pkg::block_t      block_i;
	sha256_pkg::hash_state_u chain_i;
	sha256_pkg::hash_state_u digest_o;
	logic                    valid_o;

	expect_t                 expected_q [$];
	logic [31:0]             adv_count = '0;
	int                      sent_count = 0;
	int                      delivered_count = 0;
	sha256_pkg::hash_state_u last_digest;

	// Output values seen on the previous edge
	logic                    hold_armed = 1'b0;
	logic                    adv_seen = 1'b0;
	logic                    valid_held = 1'b0;
	sha256_pkg::hash_state_u digest_held;

	sha256_pipeline uut (
		.CLK      (CLK),
		.RST      (RST),
		.adv_i    (adv_i),
		.valid_i  (valid_i),
		.block_i  (block_i),
		.chain_i  (chain_i),
		.digest_o (digest_o),
		.valid_o  (valid_o)
	);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("STATUS: FAIL");
		$fatal(1, "watchdog expired");
	end

	task automatic report_mismatch(input string name, input logic [255:0] expected,
		input logic [255:0] actual);
		$display("[FAIL] %0t ns %s expected %h actual %h", $time, name, expected, actual);
		$display("STATUS: FAIL");
		$fatal(1, "wrong value on %s", name);
	endtask

	task automatic report_event(input string what);
		$display("Error at %0t ns: %s", $time, what);
		$display("STATUS: FAIL");
		$fatal(1, "%s", what);
	endtask

	function automatic sha256_pkg::block_t random_block();
		sha256_pkg::block_t blk;
		for (int i = 0; i < 16; i++) begin
			blk[i] = $urandom;
		end
		return blk;
	endfunction

	function automatic sha256_pkg::hash_state_u random_state();
		sha256_pkg::hash_state_u s;
		for (int i = 0; i < 8; i++) begin
			s.words[i] = $urandom;
		end
		return s;
	endfunction

	task automatic step(input logic adv, input logic valid, input sha256_pkg::block_t blk,
		input sha256_pkg::hash_state_u chain);
		adv_i   <= adv;
		valid_i <= valid;
		block_i <= blk;
		chain_i <= chain;
		@(posedge CLK);
	endtask

	task automatic send(input sha256_pkg::block_t blk, input sha256_pkg::hash_state_u chain);
		step(1'b1, 1'b1, blk, chain);
		sent_count++;
	endtask

	// Bubbles with junk data until every block is out
	task automatic drain();
		while (delivered_count != sent_count) begin
			step(1'b1, 1'b0, random_block(), random_state());
		end
	endtask

	always @(posedge CLK) begin : scoreboard
		expect_t head;
		expect_t entry;
		if (RST) begin
			if (hold_armed && !adv_seen) begin
				assert (valid_o === valid_held)
					else report_mismatch("valid_o", 256'(valid_held), 256'(valid_o));
				assert (digest_o === digest_held)
					else report_mismatch("digest_o", digest_held, digest_o);
			end
			if (valid_o) begin
				assert (expected_q.size() > 0)
					else report_event("valid_o is high with no block in flight");
			end
			if (adv_i) begin
				adv_count = adv_count + 32'd1;
				if (valid_o) begin
					head = expected_q.pop_front();
					assert (digest_o == head.digest)
						else report_mismatch("digest_o", head.digest, digest_o);
					assert (adv_count - head.adv_index == 32'(LATENCY))
						else report_event("result did not arrive 65 advances after its block");
					delivered_count <= delivered_count + 1;
					last_digest     <= digest_o;
				end
				if (valid_i) begin
					entry.digest    = compress_block(chain_i, block_i);
					entry.adv_index = adv_count;
					expected_q.push_back(entry);
				end
			end
		end
		hold_armed  <= RST;
		adv_seen    <= adv_i;
		valid_held  <= valid_o;
		digest_held <= digest_o;
	end

	initial begin : stimulus
		sha256_pkg::hash_state_u chain;
		void'($urandom(83516));
		RST     = 1'b0;
		adv_i   = 1'b0;
		valid_i = 1'b0;
		block_i = '0;
		chain_i = '0;
		repeat (4) @(posedge CLK);
		RST <= 1'b1;
		@(posedge CLK);
		assert (valid_o === 1'b0) else report_mismatch("valid_o", 256'(0), 256'(valid_o));
		assert (digest_o === '0) else report_mismatch("digest_o", '0, digest_o);

		send(ABC_BLOCK, sha256_pkg::HASH_IV);
		drain();
		assert (last_digest == ABC_DIGEST)
			else report_mismatch("digest_o", ABC_DIGEST, last_digest);

		// First digest comes back as the chain of block two
		send(TWO_BLOCK_0, sha256_pkg::HASH_IV);
		drain();
		chain = last_digest;
		send(TWO_BLOCK_1, chain);
		drain();
		assert (last_digest == TWO_DIGEST)
			else report_mismatch("digest_o", TWO_DIGEST, last_digest);

		for (int i = 0; i < N_BURST; i++) begin
			send(random_block(), random_state());
		end
		drain();

		// Stalls and bubbles mixed in
		for (int i = 0; i < N_MIXED; i++) begin
			automatic logic adv = ($urandom % 100) < 65;
			automatic logic valid = ($urandom % 100) < 60;
			step(adv, valid, random_block(), random_state());
			if (adv && valid) begin
				sent_count++;
			end
		end
		drain();

		$display("STATUS: PASS");
		$finish;
	end

endmodule

//--- source/sha256_pipeline.sv
`timescale 1ns/1ps

module sha256_pipeline (
	input  logic                    CLK,
	input  logic                    RST,
	input  logic                    adv_i,
	input  logic                    valid_i,
	input  sha256_pkg::block_t      block_i,
	input  sha256_pkg::hash_state_u chain_i,
	output sha256_pkg::hash_state_u digest_o,
	output logic                    valid_o
);

	// stage[t] feeds round t, stage[ROUNDS] feeds the final add
	sha256_pkg::stage_t stage [0:sha256_pkg::ROUNDS];

	// window[t] holds W[t] in word 0
	sha256_pkg::block_t window [0:sha256_pkg::ROUNDS-1];

	// Working state starts from the chaining value
	assign stage[0] = '{valid: valid_i, chain: chain_i, state: chain_i};
	assign window[0] = block_i;

	generate
		for (genvar t = 0; t < sha256_pkg::ROUNDS; t++) begin : g_round
			sha256_round_stage #(
				.ROUND(t)
			) u_round (
				.CLK     (CLK),
				.RST     (RST),
				.adv_i   (adv_i),
				.w_i     (window[t][0]),
				.stage_i (stage[t]),
				.stage_o (stage[t+1])
			);

			// Window t+1 moves on the same advance as round t
			if (t < sha256_pkg::ROUNDS - 1) begin : g_sched
				sha256_sched_stage #(
					.ROUND(t)
				) u_sched (
					.CLK      (CLK),
					.RST      (RST),
					.adv_i    (adv_i),
					.window_i (window[t]),
					.window_o (window[t+1])
				);
			end
		end
	endgenerate

	sha256_final_add u_final (
		.CLK      (CLK),
		.RST      (RST),
		.adv_i    (adv_i),
		.stage_i  (stage[sha256_pkg::ROUNDS]),
		.digest_o (digest_o),
		.valid_o  (valid_o)
	);

endmodule

//--- source/sha256_final_add.sv
`timescale 1ns/1ps

module sha256_final_add (
	input  logic                    CLK,
	input  logic                    RST,
	input  logic                    adv_i,
	input  sha256_pkg::stage_t      stage_i,
	output sha256_pkg::hash_state_u digest_o,
	output logic                    valid_o
);

	sha256_pkg::hash_state_u sum;

	// Word-wise add, mod 2^32
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			sum.words[i] = stage_i.chain.words[i] + stage_i.state.words[i];
		end
	end

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			valid_o  <= 1'b0;
			digest_o <= '0;
		end else if (adv_i) begin
			valid_o  <= stage_i.valid;
			digest_o <= sum;
		end
	end

endmodule

//--- source/sha256_round_stage.sv
`timescale 1ns/1ps

module sha256_round_stage #(
	parameter int ROUND = 0
) (
	input  logic               CLK,
	input  logic               RST,
	input  logic               adv_i,
	input  sha256_pkg::word_t  w_i,
	input  sha256_pkg::stage_t stage_i,
	output sha256_pkg::stage_t stage_o
);

	localparam sha256_pkg::word_t K = sha256_pkg::round_k[ROUND];

	sha256_pkg::hash_vars_t  vars_in;
	sha256_pkg::hash_vars_t  vars_next;
	sha256_pkg::word_t       t1;
	sha256_pkg::word_t       t2;

	logic                    valid_q;
	sha256_pkg::hash_state_u chain_q;
	sha256_pkg::hash_state_u state_q;

	assign vars_in = stage_i.state.vars;

	always_comb begin
		t1 = vars_in.h
			+ sha256_pkg::big_sigma1(vars_in.e)
			+ sha256_pkg::ch(vars_in.e, vars_in.f, vars_in.g)
			+ K
			+ w_i;
		t2 = sha256_pkg::big_sigma0(vars_in.a)
			+ sha256_pkg::maj(vars_in.a, vars_in.b, vars_in.c);

		vars_next.a = t1 + t2;
		vars_next.b = vars_in.a;
		vars_next.c = vars_in.b;
		vars_next.d = vars_in.c;
		vars_next.e = vars_in.d + t1;
		vars_next.f = vars_in.e;
		vars_next.g = vars_in.f;
		vars_next.h = vars_in.g;
	end

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			valid_q <= 1'b0;
		end else if (adv_i) begin
			valid_q <= stage_i.valid;
		end
	end

	// Chaining value rides along with its own block
	always_ff @(posedge CLK) begin
		if (adv_i) begin
			chain_q      <= stage_i.chain;
			state_q.vars <= vars_next;
		end
	end

	assign stage_o = '{valid: valid_q, chain: chain_q, state: state_q};

endmodule

//--- source/sha256_sched_stage.sv
`timescale 1ns/1ps

module sha256_sched_stage #(
	parameter int ROUND = 0
) (
	input  logic               CLK,
	input  logic               RST,
	input  logic               adv_i,
	input  sha256_pkg::block_t window_i,
	output sha256_pkg::block_t window_o
);

	// Rounds from here on never read a newly expanded word
	localparam int EXPAND_LIMIT = sha256_pkg::ROUNDS - sha256_pkg::SCHED_WORDS;

	sha256_pkg::word_t  w_next;
	sha256_pkg::block_t window_next;

	generate
		if (ROUND < EXPAND_LIMIT) begin : g_expand
			// W[t+16] from W[t], W[t+1], W[t+9] and W[t+14]
			assign w_next = sha256_pkg::small_sigma1(window_i[14])
				+ window_i[9]
				+ sha256_pkg::small_sigma0(window_i[1])
				+ window_i[0];
		end else begin : g_tail
			assign w_next = '0;
		end
	endgenerate

	// Drop the consumed word, append the new one at the bottom
	assign window_next = {window_i[1:sha256_pkg::SCHED_WORDS-1], w_next};

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			window_o <= '0;
		end else if (adv_i) begin
			window_o <= window_next;
		end
	end

endmodule

//--- source/sha256_pkg.sv
package sha256_pkg;

	localparam int ROUNDS = 64;
	localparam int SCHED_WORDS = 16;

	typedef logic [31:0] word_t;

	// Word 0 sits in the top bits of the block
	typedef word_t [0:SCHED_WORDS-1] block_t;

	typedef struct packed {
		word_t a;
		word_t b;
		word_t c;
		word_t d;
		word_t e;
		word_t f;
		word_t g;
		word_t h;
	} hash_vars_t;

	// Round logic sees a..h, the chaining addition sees plain words
	typedef union packed {
		hash_vars_t       vars;
		word_t [0:7]      words;
	} hash_state_u;

	typedef struct packed {
		logic        valid;
		hash_state_u chain;
		hash_state_u state;
	} stage_t;

	localparam word_t round_k [0:ROUNDS-1] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	localparam hash_state_u HASH_IV = {
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};

	function automatic word_t rotr(input word_t x, input int unsigned n);
		return (x >> n) | (x << (32 - n));
	endfunction

	// Message schedule
	function automatic word_t small_sigma0(input word_t x);
		return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
	endfunction

	function automatic word_t small_sigma1(input word_t x);
		return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
	endfunction

	// Compression round
	function automatic word_t big_sigma0(input word_t x);
		return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
	endfunction

	function automatic word_t big_sigma1(input word_t x);
		return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
	endfunction

	function automatic word_t ch(input word_t x, input word_t y, input word_t z);
		return (x & y) ^ (~x & z);
	endfunction

	function automatic word_t maj(input word_t x, input word_t y, input word_t z);
		return (x & y) ^ (x & z) ^ (y & z);
	endfunction

endpackage
